// ==== hw/nn_pkg.sv ====
package nn_pkg;

	//////////////////////////////////////////////////
	// widths
	localparam int DWIDTH    = 32;
	localparam int FRAC_BITS = 10;
	localparam int IWIDTH    = 64;
	localparam int NEURONS   = 16;
	localparam int AWIDTH    = 10;
	localparam int ROW_SEL_W = 4;

	// input index, wide enough to also count the bias item
	localparam int IDX_W = $clog2(IWIDTH + 1);

	//////////////////////////////////////////////////
	// row memory layout
	localparam int L1_BIAS_ADDR = 64;
	localparam int L2_BASE      = 65;
	localparam int L2_BIAS_ADDR = 81;

	//////////////////////////////////////////////////
	// data types
	typedef logic signed [DWIDTH-1:0] word_t;
	typedef word_t word_vec_t [NEURONS];

	// 0 is the hidden layer, 1 the output layer
	typedef logic layer_t;

	localparam layer_t LAYER_HIDDEN = 1'b0;
	localparam layer_t LAYER_OUTPUT = 1'b1;

	// fixed point 1.0 and 0.5
	localparam word_t ONE  = word_t'(1 << FRAC_BITS);
	localparam word_t HALF = word_t'(1 << (FRAC_BITS - 1));

endpackage

// ==== hw/nn_ifs.sv ====
`timescale 1ns/1ps

// one item per input, issued by the sequencer
interface fetch_if;
	import nn_pkg::*;

	logic             valid;
	layer_t           layer;
	logic [IDX_W-1:0] index;
	logic             bias;
	logic             last;

	modport source (output valid, layer, index, bias, last);
	modport sink   (input valid, layer, index, bias, last);
endinterface

// input value next to the weight row read for it
interface term_if;
	import nn_pkg::*;

	logic      valid;
	layer_t    layer;
	logic      bias;
	logic      last;
	word_t     x;
	word_vec_t weights;

	modport source (output valid, layer, bias, last, x, weights);
	modport sink   (input valid, layer, bias, last, x, weights);
endinterface

// finished weighted sums of one layer
interface sum_if;
	import nn_pkg::*;

	logic      valid;
	layer_t    layer;
	word_vec_t z;

	modport source (output valid, layer, z);
	modport sink   (input valid, layer, z);
endinterface

// ==== hw/nn_sequencer.sv ====
`timescale 1ns/1ps

module nn_sequencer (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    arm,
	input  logic    stop,
	input  logic    layer_done,
	fetch_if.source fetch,
	output logic    busy
);
	import nn_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_L1,
		ST_WAIT,
		ST_L2
	} state_t;

	state_t           state;
	layer_t           layer_q;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] bias_idx;
	logic             issuing;

	// the bias item follows the last input of the layer
	assign bias_idx = (layer_q == LAYER_HIDDEN) ? IDX_W'(IWIDTH) : IDX_W'(NEURONS);
	assign issuing  = (state == ST_L1) || (state == ST_L2);
	assign busy     = (state != ST_IDLE);

	//////////////////////////////////////////////////
	// fetch items, one per cycle while issuing
	assign fetch.valid = issuing && !stop;
	assign fetch.layer = layer_q;
	assign fetch.index = idx;
	assign fetch.bias  = issuing && (idx == bias_idx);
	assign fetch.last  = fetch.bias;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			layer_q <= LAYER_HIDDEN;
			idx     <= '0;
		end else if (stop) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (arm) begin
						state   <= ST_L1;
						layer_q <= LAYER_HIDDEN;
						idx     <= '0;
					end
				end
				ST_L1, ST_L2: begin
					if (idx == bias_idx)
						state <= ST_WAIT;
					else
						idx <= idx + 1'b1;
				end
				ST_WAIT: begin
					// hidden layer done starts layer 2, output layer done ends the run
					if (layer_done) begin
						if (layer_q == LAYER_HIDDEN) begin
							state   <= ST_L2;
							layer_q <= LAYER_OUTPUT;
							idx     <= '0;
						end else begin
							state <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// idle without arm means no item next cycle
	a_no_fetch_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && !arm) |=> !fetch.valid);

endmodule

// ==== hw/weight_memory.sv ====
`timescale 1ns/1ps

module weight_memory #(
	parameter int NEURONS = nn_pkg::NEURONS
) (
	input  logic                                        clk,
	fetch_if.sink                                       fetch,
	output nn_pkg::word_vec_t                           weights,
	input  logic [nn_pkg::ROW_SEL_W+nn_pkg::AWIDTH-1:0] host_addr,
	input  logic                                        host_en,
	input  logic                                        host_we,
	input  nn_pkg::word_t                               host_wdata,
	output nn_pkg::word_t                               host_rdata
);
	import nn_pkg::*;

	localparam int DEPTH = 1 << AWIDTH;

	// one array per neuron row
	word_t mem [NEURONS][DEPTH];

	logic [AWIDTH-1:0]    rd_addr;
	logic [ROW_SEL_W-1:0] host_row;
	logic [AWIDTH-1:0]    host_word;

	assign host_row  = host_addr[AWIDTH +: ROW_SEL_W];
	assign host_word = host_addr[AWIDTH-1:0];

	// layer, index and bias flag to row address
	always_comb begin
		if (fetch.layer == LAYER_HIDDEN)
			rd_addr = fetch.bias ? AWIDTH'(L1_BIAS_ADDR) : AWIDTH'(fetch.index);
		else
			rd_addr = fetch.bias ? AWIDTH'(L2_BIAS_ADDR) : AWIDTH'(L2_BASE + fetch.index);
	end

	always_ff @(posedge clk) begin
		for (int n = 0; n < NEURONS; n++) begin
			if (host_en && host_we && (host_row == ROW_SEL_W'(n)))
				mem[n][host_word] <= host_wdata;
			if (fetch.valid)
				weights[n] <= mem[n][rd_addr];
		end
		// host read, data one cycle after the strobe
		if (host_en && !host_we)
			host_rdata <= mem[host_row][host_word];
	end

endmodule

// ==== hw/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      arm,
	input  logic                      busy,
	input  logic [nn_pkg::IWIDTH-1:0] image,
	input  nn_pkg::word_vec_t         hidden_act,
	fetch_if.sink                     fetch,
	input  nn_pkg::word_vec_t         weights,
	term_if.source                    term
);
	import nn_pkg::*;

	localparam int PIX_W = $clog2(IWIDTH);
	localparam int HID_W = $clog2(NEURONS);

	logic [IWIDTH-1:0] image_q;
	word_t             x_next;

	// image is held for the whole run
	always_ff @(posedge clk) begin
		if (arm && !busy)
			image_q <= image;
	end

	// input value of the current item
	always_comb begin
		if (fetch.bias)
			x_next = ONE;
		else if (fetch.layer == LAYER_HIDDEN)
			x_next = image_q[fetch.index[PIX_W-1:0]] ? ONE : '0;
		else
			x_next = hidden_act[fetch.index[HID_W-1:0]];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			term.valid <= 1'b0;
			term.layer <= LAYER_HIDDEN;
			term.bias  <= 1'b0;
			term.last  <= 1'b0;
		end else begin
			term.valid <= fetch.valid;
			term.layer <= fetch.layer;
			term.bias  <= fetch.bias;
			term.last  <= fetch.last;
		end
	end

	always_ff @(posedge clk) begin
		term.x <= x_next;
	end

	// memory read data lands in the same cycle as x
	assign term.weights = weights;

endmodule

// ==== hw/mac_array.sv ====
`timescale 1ns/1ps

module mac_array #(
	parameter int NEURONS = nn_pkg::NEURONS
) (
	input  logic  clk,
	input  logic  rst_n,
	term_if.sink  term,
	sum_if.source sum
);
	import nn_pkg::*;

	word_vec_t acc;
	word_t     scaled [NEURONS];
	logic      prev_valid;

	// weight times input, back to 10 fraction bits
	for (genvar n = 0; n < NEURONS; n++) begin : g_mul
		logic signed [2*DWIDTH-1:0] prod;

		assign prod      = term.weights[n] * term.x;
		assign scaled[n] = word_t'(prod >>> FRAC_BITS);
	end

	//////////////////////////////////////////////////
	// accumulate
	// items of a layer come back to back, so a valid after an idle cycle opens a layer
	always_ff @(posedge clk) begin
		if (term.valid) begin
			for (int n = 0; n < NEURONS; n++) begin
				if (term.bias)
					acc[n] <= acc[n] + term.weights[n];
				else if (!prev_valid)
					acc[n] <= scaled[n];
				else
					acc[n] <= acc[n] + scaled[n];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prev_valid <= 1'b0;
			sum.valid  <= 1'b0;
			sum.layer  <= LAYER_HIDDEN;
		end else begin
			prev_valid <= term.valid;
			sum.valid  <= term.valid && term.bias;
			if (term.valid && term.bias)
				sum.layer <= term.layer;
		end
	end

	assign sum.z = acc;

	// bias closes the layer and is followed by a gap
	a_bias_is_last: assert property (@(posedge clk) disable iff (!rst_n)
		(term.valid && term.bias) |-> term.last ##1 !term.valid);

endmodule

// ==== hw/activation_unit.sv ====
`timescale 1ns/1ps

module activation_unit #(
	parameter int NEURONS = nn_pkg::NEURONS
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stop,
	sum_if.sink               sum,
	output nn_pkg::word_vec_t hidden_act,
	output logic              layer_done,
	output logic              finish,
	output logic [NEURONS-1:0] result
);
	import nn_pkg::*;

	word_vec_t act;
	logic      stop_q;
	logic      accept;
	logic      finish_q;

	// hard sigmoid, z/4 + 0.5 clamped to 0..1
	function automatic word_t hard_sigmoid(word_t z);
		word_t a;
		a = (z >>> 2) + HALF;
		if (a < 0)
			return '0;
		if (a > ONE)
			return ONE;
		return a;
	endfunction

	always_comb begin
		for (int n = 0; n < NEURONS; n++)
			act[n] = hard_sigmoid(sum.z[n]);
	end

	// sums still in flight when stop arrives are dropped
	assign accept = sum.valid && !stop && !stop_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stop_q     <= 1'b0;
			layer_done <= 1'b0;
			finish_q   <= 1'b0;
			result     <= '0;
		end else begin
			stop_q     <= stop;
			layer_done <= accept;
			finish_q   <= accept && (sum.layer == LAYER_OUTPUT);
			if (accept && (sum.layer == LAYER_OUTPUT)) begin
				for (int n = 0; n < NEURONS; n++)
					result[n] <= (act[n] >= HALF);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && (sum.layer == LAYER_HIDDEN))
			hidden_act <= act;
	end

	assign finish = finish_q && !stop;

	a_no_finish_near_stop: assert property (@(posedge clk) disable iff (!rst_n)
		(stop || $past(stop) || $past(stop, 2)) |-> !finish);

endmodule

// ==== hw/nn_top.sv ====
`timescale 1ns/1ps

module nn_top #(
	parameter int NEURONS = nn_pkg::NEURONS
) (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           arm,
	input  logic                                           stop,
	input  logic [nn_pkg::IWIDTH-1:0]                      image,
	output logic                                           finish,
	output logic [NEURONS-1:0]                             result,
	input  logic [nn_pkg::ROW_SEL_W+nn_pkg::AWIDTH-1:0]    host_addr,
	input  logic                                           host_en,
	input  logic                                           host_we,
	input  nn_pkg::word_t                                  host_wdata,
	output nn_pkg::word_t                                  host_rdata
);
	import nn_pkg::*;

	logic      busy;
	logic      layer_done;
	word_vec_t hidden_act;
	word_vec_t weights;

	fetch_if fetch_bus ();
	term_if  term_bus ();
	sum_if   sum_bus ();

	nn_sequencer u_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.arm        (arm),
		.stop       (stop),
		.layer_done (layer_done),
		.fetch      (fetch_bus.source),
		.busy       (busy)
	);

	weight_memory #(.NEURONS(NEURONS)) u_weight_memory (
		.clk        (clk),
		.fetch      (fetch_bus.sink),
		.weights    (weights),
		.host_addr  (host_addr),
		.host_en    (host_en),
		.host_we    (host_we),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	operand_fetch u_operand_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.arm        (arm),
		.busy       (busy),
		.image      (image),
		.hidden_act (hidden_act),
		.fetch      (fetch_bus.sink),
		.weights    (weights),
		.term       (term_bus.source)
	);

	mac_array #(.NEURONS(NEURONS)) u_mac_array (
		.clk   (clk),
		.rst_n (rst_n),
		.term  (term_bus.sink),
		.sum   (sum_bus.source)
	);

	activation_unit #(.NEURONS(NEURONS)) u_activation_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.stop       (stop),
		.sum        (sum_bus.sink),
		.hidden_act (hidden_act),
		.layer_done (layer_done),
		.finish     (finish),
		.result     (result)
	);

endmodule

// ==== tests/nn_model.svh ====
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// reference weights, row n holds neuron n of each layer
word_t w1 [NEURONS][IWIDTH];
word_t b1 [NEURONS];
word_t w2 [NEURONS][NEURONS];
word_t b2 [NEURONS];

// weight times input, kept at 10 fraction bits
function automatic word_t ref_term(word_t w, word_t x);
	longint p;
	p = longint'(w) * longint'(x);
	return word_t'(p >>> FRAC_BITS);
endfunction

// z/4 + 0.5, limited to 0..1.0
function automatic word_t ref_sigmoid(word_t z);
	word_t a;
	a = (z >>> 2) + HALF;
	if (a < 0)
		a = 0;
	else if (a > ONE)
		a = ONE;
	return a;
endfunction

// full forward pass, one result bit per output neuron
function automatic logic [NEURONS-1:0] predict(logic [IWIDTH-1:0] img);
	word_t              h [NEURONS];
	word_t              z;
	logic [NEURONS-1:0] r;
	for (int n = 0; n < NEURONS; n++) begin
		z = b1[n];
		for (int i = 0; i < IWIDTH; i++)
			z += ref_term(w1[n][i], img[i] ? ONE : '0);
		h[n] = ref_sigmoid(z);
	end
	for (int n = 0; n < NEURONS; n++) begin
		z = b2[n];
		for (int j = 0; j < NEURONS; j++)
			z += ref_term(w2[n][j], h[j]);
		r[n] = (ref_sigmoid(z) >= HALF);
	end
	return r;
endfunction

`endif

// ==== tests/nn_tb.sv ====
`timescale 1ns/1ps

module nn_tb;
	import nn_pkg::*;

	localparam int HADDR_W = ROW_SEL_W + AWIDTH;
	localparam int TIMEOUT = 500;

	logic               clk;
	logic               rst_n;
	logic               arm;
	logic               stop;
	logic [IWIDTH-1:0]  image;
	logic               finish;
	logic [NEURONS-1:0] result;
	logic [HADDR_W-1:0] host_addr;
	logic               host_en;
	logic               host_we;
	word_t              host_wdata;
	word_t              host_rdata;

	int          checks;
	int          errors;
	int          tests;
	int          checks_at_start;
	int          errors_at_start;
	logic [31:0] lfsr;

	`include "nn_model.svh"

	nn_top #(.NEURONS(NEURONS)) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.arm        (arm),
		.stop       (stop),
		.image      (image),
		.finish     (finish),
		.result     (result),
		.host_addr  (host_addr),
		.host_en    (host_en),
		.host_we    (host_we),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// random numbers and checks
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], next_bit()};
		return v;
	endfunction

	// about -2.0 .. 2.0
	function automatic word_t small_word();
		logic [63:0] v;
		v = rand_bits(12);
		return word_t'($signed(v[11:0]));
	endfunction

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		a_value: assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_cond(logic ok, string what);
		checks++;
		a_cond: assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic end_test(string name);
		tests++;
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - checks_at_start, errors - errors_at_start);
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	//////////////////////////////////////////////////
	// bus and run helpers
	// inputs change 2 ns after the edge, outputs are read at the same point
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic host_access(int row, int word, logic we, word_t data);
		host_en    = 1'b1;
		host_we    = we;
		host_addr  = {ROW_SEL_W'(row), AWIDTH'(word)};
		host_wdata = data;
		tick();
		host_en = 1'b0;
	endtask

	function automatic word_t layout_word(int n, int a);
		if (a < L1_BIAS_ADDR)
			return w1[n][a];
		if (a == L1_BIAS_ADDR)
			return b1[n];
		if (a < L2_BIAS_ADDR)
			return w2[n][a - L2_BASE];
		return b2[n];
	endfunction

	task automatic fill_weights(logic zero);
		for (int n = 0; n < NEURONS; n++) begin
			for (int i = 0; i < IWIDTH; i++)
				w1[n][i] = zero ? '0 : small_word();
			for (int j = 0; j < NEURONS; j++)
				w2[n][j] = zero ? '0 : small_word();
			b1[n] = zero ? '0 : small_word();
			b2[n] = zero ? '0 : small_word();
		end
		for (int n = 0; n < NEURONS; n++)
			for (int a = 0; a <= L2_BIAS_ADDR; a++)
				host_access(n, a, 1'b1, layout_word(n, a));
	endtask

	task automatic count_finishes(int cycles, output int n);
		n = 0;
		for (int c = 0; c < cycles; c++) begin
			tick();
			if (finish)
				n++;
		end
	endtask

	task automatic run_image(logic [IWIDTH-1:0] img, string name);
		logic seen;
		seen  = 1'b0;
		image = img;
		arm   = 1'b1;
		tick();
		arm = 1'b0;
		for (int c = 0; c < TIMEOUT && !seen; c++) begin
			tick();
			seen = finish;
		end
		check_cond(seen, {"finish did not arrive before the timeout in ", name});
		if (seen)
			check_value("result", result, predict(img));
		tick();
	endtask

	//////////////////////////////////////////////////
	initial begin
		word_t              host_exp [24];
		logic [IWIDTH-1:0]  img;
		logic [NEURONS-1:0] held;
		int                 n;
		lfsr = 32'h97d9;
		checks = 0;
		errors = 0;
		tests = 0;
		checks_at_start = 0;
		errors_at_start = 0;
		rst_n = 1'b0;
		arm = 1'b0;
		stop = 1'b0;
		image = '0;
		host_addr = '0;
		host_en = 1'b0;
		host_we = 1'b0;
		host_wdata = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		tick();
		check_value("finish", finish, 0);
		check_value("result", result, 0);
		end_test("reset");

		// distinct row and word per access
		for (int i = 0; i < 24; i++) begin
			host_exp[i] = word_t'(rand_bits(32));
			host_access(i % 16, (i * 53 + 7) % 1024, 1'b1, host_exp[i]);
		end
		for (int i = 0; i < 24; i++) begin
			host_access(i % 16, (i * 53 + 7) % 1024, 1'b0, '0);
			check_value("host_rdata", host_rdata, host_exp[i]);
		end
		end_test("host port");

		fill_weights(1'b1);
		run_image(rand_bits(64), "zero weights");
		check_value("result", result, {NEURONS{1'b1}});
		end_test("zero weights");

		fill_weights(1'b0);
		for (int k = 0; k < 6; k++)
			run_image(rand_bits(64), "random weights");
		end_test("random weights");

		held  = result;
		img   = rand_bits(64);
		image = img;
		arm   = 1'b1;
		tick();
		arm = 1'b0;
		repeat (4) tick();
		stop = 1'b1;
		tick();
		stop = 1'b0;
		count_finishes(300, n);
		check_value("finish count", n, 0);
		check_value("result", result, held);
		run_image(img, "run after stop");
		end_test("stop");

		// extra arms and a new image while the run is busy
		img   = rand_bits(64);
		image = img;
		arm   = 1'b1;
		tick();
		arm   = 1'b0;
		image = ~img;
		for (int k = 0; k < 4; k++) begin
			repeat (8) tick();
			arm   = 1'b1;
			image = rand_bits(64);
			tick();
			arm = 1'b0;
		end
		count_finishes(TIMEOUT, n);
		check_value("finish count", n, 1);
		check_value("result", result, predict(img));
		end_test("arm while busy");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+tests
hw/nn_pkg.sv
hw/nn_ifs.sv
hw/nn_sequencer.sv
hw/weight_memory.sv
hw/operand_fetch.sv
hw/mac_array.sv
hw/activation_unit.sv
hw/nn_top.sv
tests/nn_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs nn_tb with Verilator, then looks for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module nn_tb -f flist.f -o nn_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/nn_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
